/* source/fp_defs.svh */
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// Wishbone word address width.
`define FP_WB_ADDR_W 3

// ~~~~~~~~~~~~~~~~~~~~
// Register word offsets
// ~~~~~~~~~~~~~~~~~~~~
`define FP_REG_A_OFS      0
`define FP_REG_B_OFS      1
`define FP_REG_CTRL_OFS   2
`define FP_REG_RESULT_OFS 3
`define FP_REG_STATUS_OFS 4

`define FP_CTRL_START_BIT 0
`define FP_STAT_DONE_BIT  0
`define FP_STAT_NAN_BIT   1

`endif

/* source/float_types_pkg.sv */
`default_nettype none

`include "fp_defs.svh"

package float_types_pkg;

  // IEEE single-precision layout.
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] mant;
  } float_point_num;

  typedef enum logic {
    OK_state   = 1'b0,
    NAN_or_INF = 1'b1   // Some operand had an all-ones exponent.
  } num_status_e;

  // Register selects, one per bus word.
  typedef enum logic [`FP_WB_ADDR_W-1:0] {
    REG_A      = `FP_REG_A_OFS,
    REG_B      = `FP_REG_B_OFS,
    REG_CTRL   = `FP_REG_CTRL_OFS,
    REG_RESULT = `FP_REG_RESULT_OFS,
    REG_STATUS = `FP_REG_STATUS_OFS
  } fp_reg_e;

endpackage

`default_nettype wire

/* source/fp_operand_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fp_operand_if;
  import float_types_pkg::*;

  float_point_num operand_a;
  float_point_num operand_b;
  logic           start;       // One-cycle pulse.

  float_point_num result;
  num_status_e    status;
  logic           done;

  modport host (
    output operand_a,
    output operand_b,
    output start,
    input  result,
    input  status,
    input  done
  );

  modport engine (
    input  operand_a,
    input  operand_b,
    input  start,
    output result,
    output status,
    output done
  );

endinterface

`default_nettype wire

/* source/comb_fp_summator.sv */
`timescale 1ns/1ps
`default_nettype none

module comb_fp_summator (
  input  float_types_pkg::float_point_num a_i,
  input  float_types_pkg::float_point_num b_i,
  output float_types_pkg::num_status_e    answer_status_o,
  output float_types_pkg::float_point_num answer_o
);
  import float_types_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // Special operands
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin : flag_special
    if ((&a_i.exp) || (&b_i.exp))
      answer_status_o = NAN_or_INF;
    else
      answer_status_o = OK_state;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Hidden bit and alignment
  // ~~~~~~~~~~~~~~~~~~~~
  logic        a_larger;
  logic [7:0]  exp_dif;
  logic [7:0]  exp_al;
  logic [23:0] a_mant;
  logic [23:0] b_mant;
  logic [23:0] a_al;
  logic [23:0] b_al;

  always_comb begin : align
    a_mant   = {|a_i.exp, a_i.mant};   // Zero exponent carries no hidden bit.
    b_mant   = {|b_i.exp, b_i.mant};
    a_larger = a_i.exp > b_i.exp;
    if (a_larger) begin
      exp_dif = a_i.exp - b_i.exp;
      exp_al  = a_i.exp;
      a_al    = a_mant;
      b_al    = b_mant >> exp_dif;     // Shifted-out bits are lost.
    end else begin
      exp_dif = b_i.exp - a_i.exp;
      exp_al  = b_i.exp;
      a_al    = a_mant >> exp_dif;
      b_al    = b_mant;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Add or subtract
  // ~~~~~~~~~~~~~~~~~~~~
  logic [24:0] mant_sum;
  logic        res_sign;

  always_comb begin : add_sub
    if (a_i.sign == b_i.sign) begin
      mant_sum = {1'b0, a_al} + {1'b0, b_al};
      res_sign = a_i.sign;
    end else if (a_al >= b_al) begin
      mant_sum = {1'b0, a_al} - {1'b0, b_al};
      res_sign = a_i.sign;             // Larger magnitude wins.
    end else begin
      mant_sum = {1'b0, b_al} - {1'b0, a_al};
      res_sign = b_i.sign;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Normalize
  // ~~~~~~~~~~~~~~~~~~~~
  logic [4:0]  lead_shift;
  logic        lead_found;
  logic [23:0] norm_mant;

  // Highest set bit below the hidden position.
  always_comb begin : find_lead_one
    lead_shift = 5'd0;
    lead_found = 1'b0;
    for (int i = 22; i >= 0; i--) begin
      if (mant_sum[i] && !lead_found) begin
        lead_shift = 5'(23 - i);
        lead_found = 1'b1;
      end
    end
  end

  always_comb begin : normalize
    norm_mant = mant_sum[23:0] << lead_shift;
    if (mant_sum == 25'd0) begin
      answer_o = '0;                   // Exact cancellation.
    end else if (mant_sum[24]) begin
      answer_o = '{sign: res_sign, exp: exp_al + 8'd1, mant: mant_sum[23:1]};
    end else if (mant_sum[23]) begin
      answer_o = '{sign: res_sign, exp: exp_al, mant: mant_sum[22:0]};
    end else begin
      answer_o = '{sign: res_sign,
                   exp:  exp_al - {3'b000, lead_shift},
                   mant: norm_mant[22:0]};
    end
  end

endmodule

`default_nettype wire

/* source/fp_add_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_unit (
  input  logic         clk_i,
  input  logic         reset_i,
  fp_operand_if.engine op
);
  import float_types_pkg::*;

  float_point_num sum;
  num_status_e    sum_status;

  comb_fp_summator u_summator (
    .a_i             (op.operand_a),
    .b_i             (op.operand_b),
    .answer_status_o (sum_status),
    .answer_o        (sum)
  );

  // A new start overwrites the result and re-arms done.
  always_ff @(posedge clk_i) begin : capture
    if (reset_i) begin
      op.result <= '0;
      op.status <= OK_state;
      op.done   <= 1'b0;
    end else if (op.start) begin
      op.result <= sum;
      op.status <= sum_status;
      op.done   <= 1'b1;
    end
  end

  // Outputs only move on the edge after a start from the bus side.
  property p_result_held;
    @(posedge clk_i) disable iff (reset_i)
      !$past(op.start) |-> ($stable(op.result) && $stable(op.status));
  endproperty

  a_result_held : assert property (p_result_held)
    else $error("fp_add_unit: result changed without a start");

endmodule

`default_nettype wire

/* source/fp_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_wb_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`FP_WB_ADDR_W-1:0] wb_adr_i,
  input  logic [31:0]              wb_dat_i,
  input  logic [3:0]               wb_sel_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o,
  fp_operand_if.host               op
);
  import float_types_pkg::*;

  fp_reg_e     reg_sel;
  logic        access;
  logic [31:0] status_word;

  assign reg_sel = fp_reg_e'(wb_adr_i);
  assign access  = wb_cyc_i && wb_stb_i && !wb_ack_o;   // Request seen while ack is low.

  // ~~~~~~~~~~~~~~~~~~~~
  // Ack and start
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin : bus_ctrl
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      op.start <= 1'b0;
    end else begin
      wb_ack_o <= access;
      op.start <= access && wb_we_i && (reg_sel == REG_CTRL) &&
                  wb_dat_i[`FP_CTRL_START_BIT];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Operand registers
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin : operand_regs
    if (reset_i) begin
      op.operand_a <= '0;
      op.operand_b <= '0;
    end else if (access && wb_we_i) begin
      case (reg_sel)
        REG_A:   op.operand_a <= float_point_num'(wb_dat_i);
        REG_B:   op.operand_b <= float_point_num'(wb_dat_i);
        default: ;                                        // Result and status are read only.
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read path
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin : build_status
    status_word                    = '0;
    status_word[`FP_STAT_DONE_BIT] = op.done;
    status_word[`FP_STAT_NAN_BIT]  = (op.status == NAN_or_INF);
  end

  always_comb begin : read_mux
    case (reg_sel)
      REG_A:      wb_dat_o = op.operand_a;
      REG_B:      wb_dat_o = op.operand_b;
      REG_RESULT: wb_dat_o = op.result;
      REG_STATUS: wb_dat_o = status_word;
      default:    wb_dat_o = '0;                          // Control reads as zero.
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus protocol checks
  // ~~~~~~~~~~~~~~~~~~~~
  a_ack_single : assert property (
    @(posedge clk_i) disable iff (reset_i) wb_ack_o |=> !wb_ack_o
  ) else $error("fp_wb_regs: ack held for two cycles");

  // Master must keep the request up until it sees ack.
  a_ack_in_cycle : assert property (
    @(posedge clk_i) disable iff (reset_i) wb_ack_o |-> (wb_cyc_i && wb_stb_i)
  ) else $error("fp_wb_regs: ack outside a bus cycle");

  a_full_word : assert property (
    @(posedge clk_i) disable iff (reset_i) (wb_cyc_i && wb_stb_i) |-> (wb_sel_i == 4'hF)
  ) else $error("fp_wb_regs: partial word access");

endmodule

`default_nettype wire

/* source/fp_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_wb_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`FP_WB_ADDR_W-1:0] wb_adr_i,
  input  logic [31:0]              wb_dat_i,
  input  logic [3:0]               wb_sel_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o
);

  fp_operand_if op_if ();

  fp_wb_regs u_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .op       (op_if.host)
  );

  fp_add_unit u_add (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .op      (op_if.engine)
  );

endmodule

`default_nettype wire

/* bench/fp_ref_model.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Double arithmetic is exact for the operands used here.
// The result is repacked into the IEEE single layout.
function automatic logic [31:0] single_bits(input real value);
  logic [63:0] dbl;
  logic [7:0]  exp8;
  dbl  = $realtobits(value);
  exp8 = 8'(dbl[62:52] - 11'd896);   // Rebias 1023 to 127.
  if (dbl[62:52] == 11'd0)
    return 32'd0;                    // Exact zero result.
  else
    return {dbl[63], exp8, dbl[51:29]};
endfunction

// All-ones exponent on either operand.
function automatic logic nan_flag(input logic [31:0] a, input logic [31:0] b);
  return (&a[30:23]) || (&b[30:23]);
endfunction

function automatic logic [31:0] expected_status(input logic done, input logic nan);
  logic [31:0] word;
  word                    = '0;
  word[`FP_STAT_DONE_BIT] = done;
  word[`FP_STAT_NAN_BIT]  = nan;
  return word;
endfunction

`endif

/* bench/fp_wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_defs.svh"

module fp_wb_tb;
  import float_types_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_XFERS   = 180;                      // Bound on bus transactions.
  localparam int WATCHDOG_NS = (NUM_XFERS * 4 + 20) * CLK_PERIOD;

  logic                     clk_i;
  logic                     reset_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`FP_WB_ADDR_W-1:0] wb_adr_i;
  logic [31:0]              wb_dat_i;
  logic [3:0]               wb_sel_i;
  logic [31:0]              wb_dat_o;
  logic                     wb_ack_o;
  integer                   seed;
  int                       error_count;
  int                       check_count;
  int                       test_count;
  int                       errors_before;

  `include "fp_ref_model.svh"

  fp_wb_top u_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Fail %s: expected %h, got %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic bus_access(input logic we, input fp_reg_e sel, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = sel;
    wb_dat_i = wdata;
    do begin
      @(negedge clk_i);
    end while (!wb_ack_o);
    rdata = wb_dat_o;
    @(negedge clk_i);                                     // Request held through the ack edge.
    check_value("wb_ack_o", 32'd0, {31'd0, wb_ack_o});
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input fp_reg_e sel, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, sel, data, ignored);
  endtask

  task automatic wb_read(input fp_reg_e sel, output logic [31:0] data);
    bus_access(1'b0, sel, '0, data);
  endtask

  task automatic run_add(input logic [31:0] a_bits, input logic [31:0] b_bits,
                         input logic [31:0] exp_sum, input logic check_res);
    logic [31:0] rdata;
    wb_write(REG_A, a_bits);
    wb_write(REG_B, b_bits);
    wb_write(REG_CTRL, 32'd1 << `FP_CTRL_START_BIT);
    if (check_res) begin
      wb_read(REG_RESULT, rdata);
      check_value("result", exp_sum, rdata);
    end
    wb_read(REG_STATUS, rdata);
    check_value("status", expected_status(1'b1, nan_flag(a_bits, b_bits)), rdata);
  endtask

  task automatic add_reals(input real a, input real b);
    run_add(single_bits(a), single_bits(b), single_bits(a + b), 1'b1);
  endtask

  // Integer of at most 12 bits with a random sign.
  function automatic int random_operand();
    int mag;
    mag = $random(seed) & 32'h0000_0FFF;
    if ($random(seed) & 32'd1)
      mag = -mag;
    return mag;
  endfunction

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
             error_count - errors_before);
    errors_before = error_count;
  endtask

  initial begin : main
    logic [31:0] rdata;
    int          ia;
    int          ib;
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = 4'hF;
    seed     = 32'h92b3;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    wb_read(REG_STATUS, rdata);
    check_value("status", expected_status(1'b0, 1'b0), rdata);
    wb_write(REG_A, single_bits(1.5));
    wb_read(REG_A, rdata);
    check_value("operand_a", single_bits(1.5), rdata);
    wb_write(REG_B, single_bits(2.25));
    wb_read(REG_B, rdata);
    check_value("operand_b", single_bits(2.25), rdata);
    wb_write(REG_RESULT, 32'hFFFF_FFFF);
    wb_read(REG_RESULT, rdata);
    check_value("result", 32'd0, rdata);
    finish_test("bus access");

    add_reals(1.5, 2.25);
    wb_write(REG_RESULT, 32'hFFFF_FFFF);                  // Read only.
    wb_read(REG_RESULT, rdata);
    check_value("result", single_bits(3.75), rdata);
    add_reals(-3.5, -0.75);
    finish_test("same sign");

    add_reals(1.0, 1.0);
    add_reals(3.0, 1.0);
    finish_test("exponent carry");

    add_reals(5.0, -4.75);
    add_reals(1.0, -0.75);
    add_reals(-5.0, 4.75);
    add_reals(2.5, -2.5);
    finish_test("cancellation");

    run_add(32'h7F80_0000, single_bits(1.0), '0, 1'b0);
    run_add(single_bits(2.0), 32'h7FC0_0000, '0, 1'b0);
    add_reals(1.5, 2.25);
    finish_test("nan or inf flag");

    for (int i = 0; i < 20; i++) begin
      ia = random_operand();
      ib = random_operand();
      add_reals($itor(ia), $itor(ib));
    end
    finish_test("random exact sums");

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
+incdir+bench
source/float_types_pkg.sv
source/fp_operand_if.sv
source/comb_fp_summator.sv
source/fp_add_unit.sv
source/fp_wb_regs.sv
source/fp_wb_top.sv
bench/fp_wb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FP adder testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module fp_wb_tb -o fp_wb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fp_wb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  exit 0
fi
exit 1
